// ==== source/bp_pkg.sv ====
`default_nettype none

package bp_pkg;

	////////////////////
	// widths
	////////////////////

	// word program counter
	localparam int PC_W = 10;
	// set index is the low part of the pc
	localparam int SET_W = 4;
	// isr bit on top of the high pc bits
	localparam int TAG_W = PC_W - SET_W + 1;

	// table geometry, 64 entries in total
	localparam int NUM_SETS = 16;
	localparam int NUM_WAYS = 4;

	typedef logic [PC_W-1:0] pc_t;
	typedef logic [SET_W-1:0] set_t;
	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [$clog2(NUM_WAYS)-1:0] way_t;
	// 2-bit saturating counter, msb is the taken prediction
	typedef logic [1:0] sat_t;
	// one-hot branch type from decode
	typedef logic [5:0] btype_t;

	// initial counters on allocation
	localparam sat_t SAT_INIT_BRANCH = 2'd1;
	localparam sat_t SAT_INIT_JUMP = 2'd3;

	// bit positions inside btype_t
	localparam int BT_BEQ = 5;
	localparam int BT_BNE = 4;
	localparam int BT_BLT = 3;
	localparam int BT_BGE = 2;
	localparam int BT_BLTU = 1;
	localparam int BT_BGEU = 0;

	////////////////////
	// structs
	////////////////////

	// one table line, 20 bits
	typedef struct packed {
		logic valid;
		tag_t tag;
		pc_t target;
		sat_t sat;
	} bht_entry_t;

	// result of a set search, entry is zero on a miss
	typedef struct packed {
		logic hit;
		way_t way;
		bht_entry_t entry;
	} lookup_t;

	// branch feedback from the exe stage
	typedef struct packed {
		pc_t pc;
		btype_t btype;
		logic z;
		logic less;
	} exe_fb_t;

	// next pc correction from exe
	typedef enum logic [1:0] {
		CORR_NONE = 2'd0,
		CORR_CNI = 2'd2,
		CORR_PBT = 2'd3
	} corr_e;

endpackage

`default_nettype wire

// ==== source/bht_lookup.sv ====
`timescale 1ns/1ps
`default_nettype none

module bht_lookup import bp_pkg::*; (
	input bht_entry_t set_entries [NUM_WAYS],
	input tag_t tag,
	output lookup_t result
);

	// one bit per way that holds a valid matching tag
	logic [NUM_WAYS-1:0] match;

	////////////////////
	// tag compare
	////////////////////

	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			match[w] = set_entries[w].valid && (set_entries[w].tag == tag);
		end
	end

	////////////////////
	// way select
	////////////////////

	// only an exactly one-hot match is a hit
	// zero match or several matches give an all zero result
	always_comb begin
		result = '0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (match == ({{(NUM_WAYS-1){1'b0}}, 1'b1} << w)) begin
				result.hit = 1'b1;
				result.way = way_t'(w);
				result.entry = set_entries[w];
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/branch_resolve.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_resolve import bp_pkg::*; (
	input exe_fb_t exe_fb,
	input lookup_t exe_hit,
	output logic exe_taken,
	output logic mispredict,
	output corr_e correction,
	output pc_t exe_pbt,
	output pc_t exe_cni
);

	// any branch type bit means a branch sits in exe
	logic is_branch;

	assign is_branch = |exe_fb.btype;

	// real outcome from the alu flags
	// unsigned compares reuse less, the alu already picked the compare
	assign exe_taken = (exe_fb.btype[BT_BEQ] && exe_fb.z)
		|| (exe_fb.btype[BT_BNE] && !exe_fb.z)
		|| (exe_fb.btype[BT_BLT] && exe_fb.less)
		|| (exe_fb.btype[BT_BGE] && !exe_fb.less)
		|| (exe_fb.btype[BT_BLTU] && exe_fb.less)
		|| (exe_fb.btype[BT_BGEU] && !exe_fb.less);

	// counter msb is what fetch predicted
	assign mispredict = is_branch && (exe_hit.entry.sat[1] != exe_taken);

	always_comb begin
		correction = CORR_NONE;
		if (mispredict) begin
			// taken but predicted not taken
			if (exe_taken)
				correction = CORR_PBT;
			else
				correction = CORR_CNI;
		end
	end

	// stored target of the branch
	assign exe_pbt = exe_hit.entry.target;
	// fall through pc rebuilt from the tag and the set
	// on a miss the tag is zero so this is set plus one
	assign exe_cni = {exe_hit.entry.tag[TAG_W-2:0], exe_fb.pc[SET_W-1:0]} + pc_t'(1);

endmodule

`default_nettype wire

// ==== source/bht_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module bht_table import bp_pkg::*; (
	input logic CLK,
	input logic nrst,
	input logic en,
	input logic isr_running,
	input pc_t if_pc,
	input pc_t id_pc,
	input pc_t id_target,
	input logic id_is_jump,
	input logic id_is_btype,
	input exe_fb_t exe_fb,
	input logic exe_taken,
	output lookup_t if_hit,
	output lookup_t exe_hit,
	output logic id_miss
);

	// table storage, one row per set
	bht_entry_t bht_mem [NUM_SETS][NUM_WAYS];
	// per set fifo replacement pointer
	way_t fifo_ptr [NUM_SETS];

	// set and tag of each stage
	set_t if_set;
	set_t id_set;
	set_t exe_set;
	tag_t if_tag;
	tag_t id_tag;
	tag_t exe_tag;

	// the four ways of each searched set
	bht_entry_t if_ways [NUM_WAYS];
	bht_entry_t id_ways [NUM_WAYS];
	bht_entry_t exe_ways [NUM_WAYS];

	lookup_t id_res;

	// write controls
	logic id_alloc;
	logic exe_update;
	bht_entry_t new_entry;
	sat_t exe_sat_next;

	////////////////////
	// address split
	////////////////////

	assign if_set = if_pc[SET_W-1:0];
	assign id_set = id_pc[SET_W-1:0];
	assign exe_set = exe_fb.pc[SET_W-1:0];

	// isr bit keeps interrupt code apart from normal code
	assign if_tag = {isr_running, if_pc[PC_W-1:SET_W]};
	assign id_tag = {isr_running, id_pc[PC_W-1:SET_W]};
	assign exe_tag = {isr_running, exe_fb.pc[PC_W-1:SET_W]};

	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			if_ways[w] = bht_mem[if_set][w];
			id_ways[w] = bht_mem[id_set][w];
			exe_ways[w] = bht_mem[exe_set][w];
		end
	end

	////////////////////
	// three searches
	////////////////////

	// fetch prediction
	bht_lookup if_lookup (
		.set_entries(if_ways),
		.tag(if_tag),
		.result(if_hit)
	);

	// allocation check in decode
	bht_lookup id_lookup (
		.set_entries(id_ways),
		.tag(id_tag),
		.result(id_res)
	);

	// counter update in exe
	bht_lookup exe_lookup (
		.set_entries(exe_ways),
		.tag(exe_tag),
		.result(exe_hit)
	);

	assign id_miss = !id_res.hit;

	////////////////////
	// write side
	////////////////////

	// new branch or jump not yet in the table
	assign id_alloc = (id_is_btype || id_is_jump) && id_miss;
	// branch resolved on an entry that exists
	assign exe_update = (|exe_fb.btype) && exe_hit.hit;

	always_comb begin
		new_entry.valid = 1'b1;
		new_entry.tag = id_tag;
		new_entry.target = id_target;
		// jumps start strongly taken, branches weakly not taken
		new_entry.sat = id_is_jump ? SAT_INIT_JUMP : SAT_INIT_BRANCH;
	end

	// step toward the outcome, hold at both ends
	always_comb begin
		exe_sat_next = exe_hit.entry.sat;
		if (exe_taken && (exe_hit.entry.sat != '1))
			exe_sat_next = exe_hit.entry.sat + sat_t'(1);
		else if (!exe_taken && (exe_hit.entry.sat != '0))
			exe_sat_next = exe_hit.entry.sat - sat_t'(1);
	end

	always_ff @(posedge CLK) begin
		if (!nrst) begin
			for (int s = 0; s < NUM_SETS; s++) begin
				fifo_ptr[s] <= '0;
				for (int w = 0; w < NUM_WAYS; w++) begin
					bht_mem[s][w].valid <= 1'b0;
				end
			end
		end else if (en) begin
			// decode allocation wins, the exe step is dropped that cycle
			if (id_alloc) begin
				bht_mem[id_set][fifo_ptr[id_set]] <= new_entry;
				fifo_ptr[id_set] <= fifo_ptr[id_set] + way_t'(1);
			end else if (exe_update) begin
				bht_mem[exe_set][exe_hit.way].sat <= exe_sat_next;
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/flush_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module flush_ctrl (
	input logic CLK,
	input logic nrst,
	input logic en,
	input logic mispredict,
	input logic id_is_jump,
	input logic id_miss,
	output logic branch_flush,
	output logic id_jump_in_bht,
	output logic id_jump_redirect
);

	// flush pending for the next enabled cycle
	logic flush_state;
	logic flush_next;

	// jump already known to the table, fetch follows the prediction
	assign id_jump_in_bht = id_is_jump && !id_miss;
	// jump not in the table yet, pc must be redirected from decode
	assign id_jump_redirect = id_is_jump && id_miss;

	always_comb begin
		if (mispredict)
			flush_next = 1'b1;
		else if (id_jump_redirect)
			flush_next = 1'b1;
		else
			flush_next = 1'b0;
	end

	always_ff @(posedge CLK) begin
		if (!nrst)
			flush_state <= 1'b0;
		else if (en)
			flush_state <= flush_next;
	end

	// flush now on a mispredict, one cycle later from the state
	assign branch_flush = flush_state || mispredict;

endmodule

`default_nettype wire

// ==== source/pc_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module pc_select import bp_pkg::*; (
	input logic CLK,
	input logic nrst,
	input logic en,
	input corr_e correction,
	input pc_t exe_pbt,
	input pc_t exe_cni,
	input pc_t id_target,
	input logic id_jump_redirect,
	input lookup_t if_hit,
	output pc_t if_pc,
	output pc_t next_pc
);

	////////////////////
	// next pc
	////////////////////

	// exe correction first, then decode redirect, then fetch prediction
	always_comb begin
		if (correction == CORR_PBT) begin
			// branch should have been taken
			next_pc = exe_pbt;
		end else if (correction == CORR_CNI) begin
			// branch should have fallen through
			next_pc = exe_cni;
		end else if (id_jump_redirect) begin
			next_pc = id_target;
		end else if (if_hit.entry.sat[1]) begin
			// entry is zero on a miss so this needs a hit
			next_pc = if_hit.entry.target;
		end else begin
			next_pc = if_pc + pc_t'(1);
		end
	end

	////////////////////
	// fetch pc register
	////////////////////

	always_ff @(posedge CLK) begin
		if (!nrst)
			if_pc <= '0;
		else if (en)
			if_pc <= next_pc;
	end

endmodule

`default_nettype wire

// ==== source/branch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_unit import bp_pkg::*; (
	input logic CLK,
	input logic nrst,
	input logic en,
	input logic isr_running,
	input pc_t id_pc,
	input pc_t id_target,
	input logic id_is_jump,
	input logic id_is_btype,
	input exe_fb_t exe_fb,
	output pc_t if_pc,
	output pc_t next_pc,
	output logic if_prediction,
	output corr_e correction,
	output logic branch_flush,
	output logic id_jump_in_bht
);

	// table search results
	lookup_t if_hit;
	lookup_t exe_hit;
	logic id_miss;

	// exe resolution
	logic exe_taken;
	logic mispredict;
	pc_t exe_pbt;
	pc_t exe_cni;

	logic id_jump_redirect;

	////////////////////
	// history table
	////////////////////

	bht_table u_table (
		.CLK(CLK),
		.nrst(nrst),
		.en(en),
		.isr_running(isr_running),
		.if_pc(if_pc),
		.id_pc(id_pc),
		.id_target(id_target),
		.id_is_jump(id_is_jump),
		.id_is_btype(id_is_btype),
		.exe_fb(exe_fb),
		.exe_taken(exe_taken),
		.if_hit(if_hit),
		.exe_hit(exe_hit),
		.id_miss(id_miss)
	);

	// taken prediction from the fetch search
	assign if_prediction = if_hit.entry.sat[1];

	////////////////////
	// exe, flush, pc
	////////////////////

	branch_resolve u_resolve (
		.exe_fb(exe_fb),
		.exe_hit(exe_hit),
		.exe_taken(exe_taken),
		.mispredict(mispredict),
		.correction(correction),
		.exe_pbt(exe_pbt),
		.exe_cni(exe_cni)
	);

	flush_ctrl u_flush (
		.CLK(CLK),
		.nrst(nrst),
		.en(en),
		.mispredict(mispredict),
		.id_is_jump(id_is_jump),
		.id_miss(id_miss),
		.branch_flush(branch_flush),
		.id_jump_in_bht(id_jump_in_bht),
		.id_jump_redirect(id_jump_redirect)
	);

	pc_select u_pc (
		.CLK(CLK),
		.nrst(nrst),
		.en(en),
		.correction(correction),
		.exe_pbt(exe_pbt),
		.exe_cni(exe_cni),
		.id_target(id_target),
		.id_jump_redirect(id_jump_redirect),
		.if_hit(if_hit),
		.if_pc(if_pc),
		.next_pc(next_pc)
	);

endmodule

`default_nettype wire

// ==== bench/clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
	output logic CLK,
	output logic nrst
);

	// 20 ns period
	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	// reset low for three rising edges, released on a falling edge
	initial begin
		nrst = 1'b0;
		repeat (3) @(posedge CLK);
		@(negedge CLK);
		nrst = 1'b1;
	end

endmodule

`default_nettype wire

// ==== bench/branch_unit_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_unit_assertions (
	input logic CLK,
	input logic nrst,
	input logic en,
	input logic mispredict,
	input logic id_jump_redirect,
	input logic flush_state,
	input logic branch_flush,
	input logic id_jump_in_bht
);

	// a mispredict flushes in its own cycle
	a_flush_on_mispredict: assert property (@(posedge CLK) disable iff (!nrst)
		mispredict |-> branch_flush)
		else $error("branch_flush low while mispredict is high");

	// setting the flush state gives a flush in the next cycle
	a_flush_follows_state: assert property (@(posedge CLK) disable iff (!nrst)
		(en && (mispredict || id_jump_redirect)) |=> (flush_state && branch_flush))
		else $error("flush state set but no branch_flush in the next cycle");

	// a jump either hits or redirects, never both
	a_jump_exclusive: assert property (@(posedge CLK) disable iff (!nrst)
		!(id_jump_in_bht && id_jump_redirect))
		else $error("id_jump_in_bht and id_jump_redirect high together");

endmodule

bind flush_ctrl branch_unit_assertions u_flush_assert (
	.CLK(CLK),
	.nrst(nrst),
	.en(en),
	.mispredict(mispredict),
	.id_jump_redirect(id_jump_redirect),
	.flush_state(flush_state),
	.branch_flush(branch_flush),
	.id_jump_in_bht(id_jump_in_bht)
);

`default_nettype wire

// ==== bench/branch_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_unit_tb import bp_pkg::*; ();

	// expected outputs of one cycle
	typedef struct packed {
		pc_t next_pc;
		corr_e corr;
		logic pred;
		logic flush;
		logic in_bht;
	} expect_t;

	logic CLK;
	logic nrst;
	logic en;
	logic isr_running;
	pc_t id_pc;
	pc_t id_target;
	logic id_is_jump;
	logic id_is_btype;
	exe_fb_t exe_fb;
	pc_t if_pc;
	pc_t next_pc;
	logic if_prediction;
	corr_e correction;
	logic branch_flush;
	logic id_jump_in_bht;

	// software copy of the table
	bht_entry_t sw_mem [NUM_SETS][NUM_WAYS];
	way_t sw_ptr [NUM_SETS];
	pc_t sw_pc;
	logic sw_flush;

	logic [31:0] lfsr_state;
	int errors;
	int test_errors;
	int tests;

	// fixed pcs used across the tests
	localparam pc_t PC_B = 10'h035;
	localparam pc_t PC_J = 10'h2a0;
	localparam pc_t PC_K = 10'h3c7;
	localparam pc_t PC_P = 10'h0e3;

	clk_gen u_clk (
		.CLK(CLK),
		.nrst(nrst)
	);

	branch_unit dut0 (
		.CLK(CLK),
		.nrst(nrst),
		.en(en),
		.isr_running(isr_running),
		.id_pc(id_pc),
		.id_target(id_target),
		.id_is_jump(id_is_jump),
		.id_is_btype(id_is_btype),
		.exe_fb(exe_fb),
		.if_pc(if_pc),
		.next_pc(next_pc),
		.if_prediction(if_prediction),
		.correction(correction),
		.branch_flush(branch_flush),
		.id_jump_in_bht(id_jump_in_bht)
	);

	//////////////////////
	// random bits
	//////////////////////

	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// one lfsr step per bit taken
	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	//////////////////////
	// reference model
	//////////////////////

	// way index or -1 unless exactly one valid way matches
	function automatic int find_way(set_t s, tag_t t);
		int hits;
		int way;
		hits = 0;
		way = -1;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (sw_mem[s][w].valid && sw_mem[s][w].tag == t) begin
				hits++;
				way = w;
			end
		end
		if (hits != 1)
			return -1;
		return way;
	endfunction

	// real branch outcome from the flags
	// unsigned types use the same less flag
	function automatic logic outcome(btype_t bt, logic z, logic less);
		case (bt)
			6'b100000: return z;
			6'b010000: return !z;
			6'b001000: return less;
			6'b000100: return !less;
			6'b000010: return less;
			6'b000001: return !less;
			default: return 1'b0;
		endcase
	endfunction

	function automatic expect_t ref_eval();
		expect_t e;
		int iw;
		int dw;
		int xw;
		bht_entry_t ie;
		bht_entry_t xe;
		logic taken;
		logic mis;
		e = '0;
		iw = find_way(sw_pc[SET_W-1:0], {isr_running, sw_pc[PC_W-1:SET_W]});
		dw = find_way(id_pc[SET_W-1:0], {isr_running, id_pc[PC_W-1:SET_W]});
		xw = find_way(exe_fb.pc[SET_W-1:0], {isr_running, exe_fb.pc[PC_W-1:SET_W]});
		ie = (iw >= 0) ? sw_mem[sw_pc[SET_W-1:0]][iw] : '0;
		xe = (xw >= 0) ? sw_mem[exe_fb.pc[SET_W-1:0]][xw] : '0;
		taken = outcome(exe_fb.btype, exe_fb.z, exe_fb.less);
		mis = (|exe_fb.btype) && (xe.sat[1] != taken);
		if (!mis)
			e.corr = CORR_NONE;
		else
			e.corr = taken ? CORR_PBT : CORR_CNI;
		// priority is exe then decode redirect then fetch prediction then pc plus one
		if (e.corr == CORR_PBT)
			e.next_pc = xe.target;
		else if (e.corr == CORR_CNI && xw >= 0)
			e.next_pc = exe_fb.pc + pc_t'(1);
		else if (e.corr == CORR_CNI)
			// a miss has no stored tag so only the set is left
			e.next_pc = pc_t'(exe_fb.pc[SET_W-1:0]) + pc_t'(1);
		else if (id_is_jump && dw < 0)
			e.next_pc = id_target;
		else if (ie.sat[1])
			e.next_pc = ie.target;
		else
			e.next_pc = sw_pc + pc_t'(1);
		e.pred = ie.sat[1];
		e.flush = sw_flush || mis;
		e.in_bht = id_is_jump && dw >= 0;
		return e;
	endfunction

	// state step of the model on an enabled edge
	task automatic model_update(expect_t e);
		int dw;
		int xw;
		set_t ds;
		set_t xs;
		logic taken;
		ds = id_pc[SET_W-1:0];
		xs = exe_fb.pc[SET_W-1:0];
		dw = find_way(ds, {isr_running, id_pc[PC_W-1:SET_W]});
		xw = find_way(xs, {isr_running, exe_fb.pc[PC_W-1:SET_W]});
		taken = outcome(exe_fb.btype, exe_fb.z, exe_fb.less);
		sw_flush = (e.corr != CORR_NONE) || (id_is_jump && dw < 0);
		// allocation wins over the counter step
		if ((id_is_btype || id_is_jump) && dw < 0) begin
			sw_mem[ds][sw_ptr[ds]] = '{valid: 1'b1, tag: {isr_running, id_pc[PC_W-1:SET_W]},
				target: id_target, sat: (id_is_jump ? 2'd3 : 2'd1)};
			sw_ptr[ds] = sw_ptr[ds] + way_t'(1);
		end else if ((|exe_fb.btype) && xw >= 0) begin
			if (taken && sw_mem[xs][xw].sat != 2'd3)
				sw_mem[xs][xw].sat = sw_mem[xs][xw].sat + 2'd1;
			else if (!taken && sw_mem[xs][xw].sat != 2'd0)
				sw_mem[xs][xw].sat = sw_mem[xs][xw].sat - 2'd1;
		end
		sw_pc = e.next_pc;
	endtask

	//////////////////////
	// compare tasks
	//////////////////////

	task automatic check_pc(string name, pc_t exp, pc_t act);
		if (exp !== act) begin
			$display("mismatch %s expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_corr(string name, corr_e exp, corr_e act);
		if (exp !== act) begin
			$display("mismatch %s expected %s actual %s", name, exp.name(), act.name());
			errors++;
		end
	endtask

	task automatic check_bit(string name, logic exp, logic act);
		if (exp !== act) begin
			$display("mismatch %s expected %b actual %b", name, exp, act);
			errors++;
		end
	endtask

	// inputs are already driven on this falling edge
	task automatic tick(string name);
		expect_t e;
		#1;
		e = ref_eval();
		check_pc({name, " if_pc"}, sw_pc, if_pc);
		check_pc({name, " next_pc"}, e.next_pc, next_pc);
		check_corr({name, " correction"}, e.corr, correction);
		check_bit({name, " prediction"}, e.pred, if_prediction);
		check_bit({name, " flush"}, e.flush, branch_flush);
		check_bit({name, " jump in bht"}, e.in_bht, id_jump_in_bht);
		if (en)
			model_update(e);
		@(negedge CLK);
	endtask

	task automatic clear_inputs();
		en = 1'b1;
		isr_running = 1'b0;
		id_pc = '0;
		id_target = '0;
		id_is_jump = 1'b0;
		id_is_btype = 1'b0;
		exe_fb = '0;
	endtask

	task automatic start_test();
		test_errors = errors;
		tests++;
	endtask

	task automatic end_test(string name);
		$display("test %s done, %0d errors", name, errors - test_errors);
	endtask

	//////////////////////
	// tests
	//////////////////////

	task automatic test_alloc();
		start_test();
		clear_inputs();
		id_is_btype = 1'b1;
		id_pc = PC_B;
		id_target = 10'h120;
		tick("alloc branch");
		// missing jump redirects to the branch pc
		clear_inputs();
		id_is_jump = 1'b1;
		id_pc = PC_J;
		id_target = PC_B;
		#1;
		check_pc("alloc redirect", PC_B, next_pc);
		check_bit("alloc redirect flush", 1'b0, branch_flush);
		tick("alloc jump");
		clear_inputs();
		#1;
		check_pc("alloc fetch branch", PC_B, if_pc);
		check_bit("alloc branch pred", 1'b0, if_prediction);
		check_pc("alloc branch next", PC_B + pc_t'(1), next_pc);
		check_bit("alloc late flush", 1'b1, branch_flush);
		tick("alloc fetch");
		clear_inputs();
		id_is_jump = 1'b1;
		id_pc = PC_K;
		id_target = PC_J;
		tick("alloc second jump");
		// stored jump predicts taken to its target
		clear_inputs();
		#1;
		check_pc("alloc fetch jump", PC_J, if_pc);
		check_bit("alloc jump pred", 1'b1, if_prediction);
		check_pc("alloc jump next", PC_B, next_pc);
		tick("alloc jump fetch");
		end_test("allocation");
	endtask

	task automatic test_counter();
		logic taken_seq [9];
		corr_e corr_seq [9];
		start_test();
		taken_seq = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
		corr_seq = '{CORR_PBT, CORR_NONE, CORR_NONE, CORR_NONE,
			CORR_CNI, CORR_CNI, CORR_NONE, CORR_NONE, CORR_PBT};
		for (int i = 0; i < 9; i++) begin
			clear_inputs();
			exe_fb.pc = PC_B;
			exe_fb.btype = 6'b100000;
			exe_fb.z = taken_seq[i];
			#1;
			check_corr("counter step", corr_seq[i], correction);
			tick("counter");
		end
		end_test("saturating counter");
	endtask

	task automatic test_random();
		pc_t pool [4];
		logic [1:0] sel;
		start_test();
		pool = '{PC_B, PC_J, PC_K, 10'h120};
		for (int i = 0; i < 40; i++) begin
			clear_inputs();
			sel = 2'(rand_bits(2));
			exe_fb.pc = pool[sel];
			exe_fb.btype = btype_t'(1) << (rand_bits(3) % 6);
			exe_fb.z = rand_bits(1) != 0;
			exe_fb.less = rand_bits(1) != 0;
			tick("random correction");
		end
		end_test("correction");
	endtask

	task automatic test_fifo();
		start_test();
		// five tags in set 9
		for (int k = 1; k <= 5; k++) begin
			clear_inputs();
			id_is_btype = 1'b1;
			id_pc = {6'(k), 4'h9};
			id_target = 10'h200 + pc_t'(k);
			tick("fifo alloc");
		end
		clear_inputs();
		id_is_jump = 1'b1;
		id_pc = 10'h029;
		#1;
		check_bit("fifo second kept", 1'b1, id_jump_in_bht);
		tick("fifo second");
		clear_inputs();
		id_is_jump = 1'b1;
		id_pc = 10'h019;
		#1;
		check_bit("fifo first evicted", 1'b0, id_jump_in_bht);
		tick("fifo first");
		end_test("fifo replacement");
	endtask

	task automatic test_isr();
		logic isr_seq [4];
		logic hit_seq [4];
		start_test();
		isr_seq = '{1'b0, 1'b1, 1'b1, 1'b0};
		hit_seq = '{1'b1, 1'b0, 1'b1, 1'b1};
		clear_inputs();
		id_is_btype = 1'b1;
		id_pc = PC_P;
		id_target = 10'h0f0;
		tick("isr alloc");
		for (int i = 0; i < 4; i++) begin
			clear_inputs();
			isr_running = isr_seq[i];
			id_is_jump = 1'b1;
			id_pc = PC_P;
			id_target = 10'h0f0;
			#1;
			check_bit("isr lookup", hit_seq[i], id_jump_in_bht);
			tick("isr");
		end
		end_test("isr separation");
	endtask

	task automatic test_enable();
		pc_t held;
		start_test();
		clear_inputs();
		held = sw_pc;
		for (int i = 0; i < 3; i++) begin
			en = 1'b0;
			id_is_jump = 1'b1;
			id_pc = 10'h3fe;
			id_target = 10'h111;
			exe_fb.pc = PC_B;
			exe_fb.btype = 6'b100000;
			#1;
			check_pc("enable hold pc", held, if_pc);
			tick("enable low");
		end
		// the jump seen with en low was never written
		clear_inputs();
		id_is_jump = 1'b1;
		id_pc = 10'h3fe;
		id_target = 10'h111;
		#1;
		check_bit("enable no write", 1'b0, id_jump_in_bht);
		tick("enable high");
		end_test("enable hold");
	endtask

	//////////////////////
	// main flow
	//////////////////////

	initial begin
		int cnt;
		clear_inputs();
		en = 1'b0;
		lfsr_state = 32'h2000_074c;
		errors = 0;
		tests = 0;
		sw_pc = '0;
		sw_flush = 1'b0;
		for (int s = 0; s < NUM_SETS; s++) begin
			sw_ptr[s] = '0;
			for (int w = 0; w < NUM_WAYS; w++)
				sw_mem[s][w] = '0;
		end
		cnt = 0;
		while (nrst !== 1'b1 && cnt < 20) begin
			@(posedge CLK);
			cnt++;
		end
		if (nrst !== 1'b1) begin
			$display("reset was never released");
			$display("=== FAIL ===");
			$finish;
		end else begin
			@(negedge CLK);
			test_alloc();
			test_counter();
			test_random();
			test_fifo();
			test_isr();
			test_enable();
			$display("%0d tests, %0d errors", tests, errors);
			if (errors == 0)
				$display("=== PASS ===");
			else
				$display("=== FAIL ===");
			$finish;
		end
	end

	// watchdog on the whole run
	initial begin
		int cycles;
		cycles = 0;
		while (cycles < 2000) begin
			@(posedge CLK);
			cycles++;
		end
		$display("simulation timed out");
		$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

// ==== branch_unit.f ====
source/bp_pkg.sv
source/bht_lookup.sv
source/branch_resolve.sv
source/bht_table.sv
source/flush_ctrl.sv
source/pc_select.sv
source/branch_unit.sv
bench/clk_gen.sv
bench/branch_unit_assertions.sv
bench/branch_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the branch unit testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module branch_unit_tb \
	-f branch_unit.f \
	--Mdir obj_dir -o sim_branch_unit

./obj_dir/sim_branch_unit | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
	echo "simulation failed"
	exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
echo "simulation passed"
